// ==== include/mdu_settings.svh ====
`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// operand and result width
`define MDU_XLEN 32

// register index tagging each request
`define MDU_IDX_W 5

// iteration counter, wide enough to reach MDU_XLEN
`define MDU_CNT_W 6

`endif

// ==== list.f ====
+incdir+include
logic/mdu_pkg.sv
logic/mdu_ctrl.sv
logic/mdu_operand_prep.sv
logic/mdu_lzc.sv
logic/mdu_iter_datapath.sv
logic/mdu_result_fix.sv
logic/mdu_top.sv
verification/mdu_tb.sv

// ==== logic/mdu_ctrl.sv ====
`include "mdu_settings.svh"

module mdu_ctrl (
	input  logic                  core_clk,
	input  logic                  core_reset_n,
	input  logic                  i_req_valid,
	input  mdu_pkg::mdu_req_t     i_req,
	input  logic                  i_kill,
	input  logic                  i_resp_ready,
	input  logic                  i_need_pre,
	input  logic                  i_special,
	input  logic [`MDU_CNT_W-1:0] i_shift_cnt,
	output logic                  o_req_ready,
	output logic                  o_resp_valid,
	output mdu_pkg::mdu_step_t    o_step,
	output mdu_pkg::mdu_op_t      o_op,
	output logic [`MDU_IDX_W-1:0] o_index
);
	import mdu_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE        = 3'd0,
		ST_PRE         = 3'd1,
		ST_EXE         = 3'd2,
		ST_POST        = 3'd3,
		ST_DONE        = 3'd4,
		ST_DIV_SHIFT   = 3'd5,
		ST_MUL_OPERAND = 3'd6
	} state_e;

	localparam int MUL_END_CNT = `MDU_XLEN - 1;
	localparam int DIV_END_CNT = `MDU_XLEN;

	state_e                state;
	state_e                state_nx;
	mdu_func_e             func_q;
	logic [`MDU_CNT_W-1:0] cnt;
	logic                  req_in;
	logic                  cnt_at_end;

	assign req_in       = i_req_valid & o_req_ready & ~i_kill;
	assign o_req_ready  = (state == ST_IDLE);
	assign o_resp_valid = (state == ST_POST) | (state == ST_DONE);

	assign o_op.mul_op    = ~func_q[2];
	// high product half for mulh*, remainder for rem*
	assign o_op.hi_result = func_q[2] ? func_q[1] : (func_q[1:0] != 2'b00);
	assign o_op.mulhsu    = (func_q == MDU_MULHSU);

	assign o_step.load      = req_in;
	assign o_step.pre       = (state == ST_PRE);
	assign o_step.dshift    = (state == ST_DIV_SHIFT);
	assign o_step.mul_first = (state == ST_MUL_OPERAND);
	assign o_step.exe       = (state == ST_EXE);
	assign o_step.post      = (state == ST_POST);

	assign cnt_at_end = o_op.mul_op ? (cnt == MUL_END_CNT[`MDU_CNT_W-1:0]) :
		(cnt == DIV_END_CNT[`MDU_CNT_W-1:0]);

	always_comb begin
		state_nx = state;
		if (i_kill) begin
			state_nx = ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_in)
						state_nx = i_need_pre ? ST_PRE :
							(i_req.func[2] ? ST_DIV_SHIFT : ST_MUL_OPERAND);
				end
				ST_PRE:         state_nx = o_op.mul_op ? ST_MUL_OPERAND : ST_DIV_SHIFT;
				ST_MUL_OPERAND: state_nx = ST_EXE;
				ST_DIV_SHIFT:   state_nx = ST_EXE;
				ST_EXE: begin
					if (i_special)
						state_nx = ST_DONE;
					else if (cnt_at_end)
						state_nx = ST_POST;
				end
				ST_POST:        state_nx = i_resp_ready ? ST_IDLE : ST_DONE;
				ST_DONE:        state_nx = i_resp_ready ? ST_IDLE : ST_DONE;
				default:        state_nx = ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n) begin
			state   <= ST_IDLE;
			func_q  <= MDU_MUL;
			o_index <= '0;
			cnt     <= '0;
		end else begin
			state <= state_nx;
			if (req_in) begin
				func_q  <= i_req.func;
				o_index <= i_req.index;
				cnt     <= '0;
			end else if (o_step.exe) begin
				// first divide step jumps past the skipped quotient bits
				if (~o_op.mul_op && cnt == '0)
					cnt <= i_shift_cnt;
				else
					cnt <= cnt + {{(`MDU_CNT_W-1){1'b0}}, 1'b1};
			end
		end
	end

	a_ready_valid_excl: assert property (@(posedge core_clk) disable iff (!core_reset_n)
		!(o_req_ready && o_resp_valid));

	a_state_legal: assert property (@(posedge core_clk) disable iff (!core_reset_n)
		state inside {ST_IDLE, ST_PRE, ST_EXE, ST_POST, ST_DONE, ST_DIV_SHIFT,
			ST_MUL_OPERAND});

endmodule

// ==== logic/mdu_iter_datapath.sv ====
`include "mdu_settings.svh"

module mdu_iter_datapath (
	input  logic                  core_clk,
	input  logic                  core_reset_n,
	input  mdu_pkg::mdu_req_t     i_req,
	input  mdu_pkg::mdu_step_t    i_step,
	input  mdu_pkg::mdu_op_t      i_op,
	input  mdu_pkg::mdu_sign_t    i_sign,
	input  logic [`MDU_XLEN-1:0]  i_abs0,
	input  logic [`MDU_XLEN-1:0]  i_abs1,
	input  logic [`MDU_CNT_W-1:0] i_shift_cnt,
	output logic [2*`MDU_XLEN:0]  o_reg0,
	output logic [`MDU_XLEN-1:0]  o_reg1
);
	// remainder or high product on top, quotient or multiplier below
	logic [2*`MDU_XLEN:0]  reg0;
	logic [2*`MDU_XLEN:0]  reg0_exe_nx;
	logic [`MDU_XLEN-1:0]  reg1;
	logic [`MDU_XLEN:0]    rs1_mul;
	logic [`MDU_XLEN:0]    adder_rs0;
	logic [`MDU_XLEN:0]    adder_rs1;
	logic [`MDU_XLEN:0]    sum;
	logic                  less;
	logic                  mul_bit;
	logic                  div_first;

	assign o_reg0 = reg0;
	assign o_reg1 = reg1;

	// reg1 holds the negated divisor during divide steps
	assign adder_rs0 = reg0[2*`MDU_XLEN:`MDU_XLEN];
	assign adder_rs1 = i_op.mul_op ? rs1_mul : {1'b1, reg1};
	assign sum       = adder_rs0 + adder_rs1;
	assign less      = sum[`MDU_XLEN];

	always_comb begin
		if (div_first)
			reg0_exe_nx = reg0 << i_shift_cnt;
		else if (i_op.mul_op)
			reg0_exe_nx = {1'b0, sum, reg0[`MDU_XLEN-1:1]};
		else if (less)
			reg0_exe_nx = {reg0[2*`MDU_XLEN-1:0], 1'b0};
		else
			reg0_exe_nx = {sum[`MDU_XLEN-1:0], reg0[`MDU_XLEN-1:0], 1'b1};
	end

	always_ff @(posedge core_clk) begin
		if (i_step.load) begin
			reg0 <= {{(`MDU_XLEN+1){1'b0}}, i_req.op0};
			reg1 <= i_req.op1;
		end else if (i_step.pre) begin
			if (i_sign.op0_signed)
				reg0 <= {{(`MDU_XLEN+1){1'b0}}, i_abs0};
			if (i_sign.op1_signed)
				reg1 <= i_abs1;
		end else if (i_step.dshift) begin
			reg1 <= ~reg1 + 1'b1;
		end else if (i_step.exe) begin
			reg0 <= reg0_exe_nx;
		end
	end

	// partial product for the next step one multiplier bit ahead
	always_ff @(posedge core_clk) begin
		if (i_step.mul_first || i_step.exe)
			rs1_mul <= mul_bit ? {1'b0, reg1} : '0;
	end

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n) begin
			mul_bit   <= 1'b0;
			div_first <= 1'b0;
		end else begin
			// negation keeps bit 0 so pre needs no update here
			if (i_step.load)
				mul_bit <= i_req.op0[0];
			else if (i_step.mul_first)
				mul_bit <= reg0[1];
			else if (i_step.exe)
				mul_bit <= reg0[2];

			if (i_step.load || i_step.exe)
				div_first <= 1'b0;
			else if (i_step.dshift)
				div_first <= 1'b1;
		end
	end

	// divide by zero must leave before a second step
	a_divisor_nonzero: assert property (@(posedge core_clk) disable iff (!core_reset_n)
		(i_step.exe && !i_op.mul_op && !div_first) |-> (reg1 != '0));

endmodule

// ==== logic/mdu_lzc.sv ====
`include "mdu_settings.svh"

module mdu_lzc (
	input  logic                  core_clk,
	input  logic                  core_reset_n,
	input  mdu_pkg::mdu_step_t    i_step,
	input  logic [`MDU_XLEN-1:0]  i_reg0_lo,
	input  logic [`MDU_XLEN-1:0]  i_reg1,
	output logic [`MDU_CNT_W-1:0] o_shift_cnt
);
	localparam int NIB       = `MDU_XLEN / 4;
	localparam int FULL_SHIFT = `MDU_XLEN;

	// 4-bit nodes merged pairwise up to 32 bits
	function automatic logic [`MDU_CNT_W-1:0] lead_zeros(input logic [`MDU_XLEN-1:0] val);
		logic [1:0] p4 [NIB];
		logic       v4 [NIB];
		logic [2:0] p8 [NIB/2];
		logic       v8 [NIB/2];
		logic [3:0] p16 [NIB/4];
		logic       v16 [NIB/4];
		logic [4:0] p32;
		logic       v32;
		for (int n = 0; n < NIB; n++) begin
			p4[n][1] = ~val[4*n+3] & ~val[4*n+2];
			p4[n][0] = ~val[4*n+3] & (val[4*n+2] | ~val[4*n+1]);
			v4[n]    = |val[4*n +: 4];
		end
		for (int n = 0; n < NIB/2; n++) begin
			v8[n] = v4[2*n+1] | v4[2*n];
			p8[n] = v4[2*n+1] ? {1'b0, p4[2*n+1]} : {1'b1, p4[2*n]};
		end
		for (int n = 0; n < NIB/4; n++) begin
			v16[n] = v8[2*n+1] | v8[2*n];
			p16[n] = v8[2*n+1] ? {1'b0, p8[2*n+1]} : {1'b1, p8[2*n]};
		end
		v32 = v16[1] | v16[0];
		p32 = v16[1] ? {1'b0, p16[1]} : {1'b1, p16[0]};
		return v32 ? {1'b0, p32} : FULL_SHIFT[`MDU_CNT_W-1:0];
	endfunction

	logic [`MDU_CNT_W-1:0] lz0;
	logic [`MDU_CNT_W-1:0] lz1;
	logic [`MDU_CNT_W-1:0] shift_nx;

	assign lz0 = lead_zeros(i_reg0_lo);
	assign lz1 = lead_zeros(i_reg1);

	// dividend smaller than divisor leaves a single step
	assign shift_nx = (lz0 > lz1) ? FULL_SHIFT[`MDU_CNT_W-1:0] :
		FULL_SHIFT[`MDU_CNT_W-1:0] - lz1 + lz0;

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n)
			o_shift_cnt <= '0;
		else if (i_step.dshift)
			o_shift_cnt <= shift_nx;
	end

endmodule

// ==== logic/mdu_operand_prep.sv ====
`include "mdu_settings.svh"

module mdu_operand_prep (
	input  logic                 core_clk,
	input  logic                 core_reset_n,
	input  mdu_pkg::mdu_req_t    i_req,
	input  mdu_pkg::mdu_step_t   i_step,
	input  mdu_pkg::mdu_op_t     i_op,
	input  logic [`MDU_XLEN-1:0] i_reg0_lo,
	input  logic [`MDU_XLEN-1:0] i_reg1,
	output logic                 o_need_pre,
	output mdu_pkg::mdu_sign_t   o_sign,
	output logic [`MDU_XLEN-1:0] o_abs0,
	output logic [`MDU_XLEN-1:0] o_abs1
);
	import mdu_pkg::*;

	logic div_signed;
	logic op0_signed_nx;
	logic op1_signed_nx;
	logic load_d1;
	logic op0_neg;
	logic op1_neg;
	logic neg_rem;
	logic neg_mul;
	logic neg_quo;
	logic div_by_zero_nx;
	logic overflow_nx;

	// div and rem are signed, divu and remu are not
	assign div_signed    = i_req.func[2] & ~i_req.func[0];
	assign op0_signed_nx = div_signed | (i_req.func inside {MDU_MUL, MDU_MULH, MDU_MULHSU});
	assign op1_signed_nx = div_signed | (i_req.func inside {MDU_MUL, MDU_MULH});

	assign o_need_pre = (op0_signed_nx & i_req.op0[`MDU_XLEN-1]) |
		(op1_signed_nx & i_req.op1[`MDU_XLEN-1]);

	// raw magnitudes, datapath picks them up only for signed operands
	assign o_abs0 = i_reg0_lo[`MDU_XLEN-1] ? (~i_reg0_lo + 1'b1) : i_reg0_lo;
	assign o_abs1 = i_reg1[`MDU_XLEN-1] ? (~i_reg1 + 1'b1) : i_reg1;

	assign op0_neg = o_sign.op0_signed & i_reg0_lo[`MDU_XLEN-1];
	assign op1_neg = o_sign.op1_signed & i_reg1[`MDU_XLEN-1];

	assign neg_rem = i_op.hi_result & ~i_op.mul_op & op0_neg;
	assign neg_mul = i_op.mul_op & (i_op.mulhsu ? op0_neg : (op0_neg ^ op1_neg));
	assign neg_quo = ~i_op.hi_result & ~i_op.mul_op & (op0_neg ^ op1_neg);

	// operands are still raw in the cycle after load
	assign div_by_zero_nx = ~i_op.mul_op & (i_reg1 == '0);
	assign overflow_nx    = ~i_op.mul_op & o_sign.op0_signed &
		(i_reg0_lo == {1'b1, {(`MDU_XLEN-1){1'b0}}}) & (i_reg1 == '1);

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n) begin
			o_sign  <= '0;
			load_d1 <= 1'b0;
		end else begin
			load_d1 <= i_step.load;
			if (i_step.load) begin
				o_sign.op0_signed <= op0_signed_nx;
				o_sign.op1_signed <= op1_signed_nx;
				o_sign.op0_msb    <= i_req.op0[`MDU_XLEN-1];
				o_sign.neg_result <= 1'b0;
			end else if (i_step.pre) begin
				o_sign.neg_result <= neg_rem | neg_mul | neg_quo;
			end
			if (load_d1) begin
				o_sign.div_by_zero <= div_by_zero_nx;
				o_sign.overflow    <= overflow_nx;
			end
		end
	end

endmodule

// ==== logic/mdu_pkg.sv ====
`include "mdu_settings.svh"

package mdu_pkg;

	// M-extension function codes
	typedef enum logic [2:0] {
		MDU_MUL    = 3'b000,
		MDU_MULH   = 3'b001,
		MDU_MULHSU = 3'b010,
		MDU_MULHU  = 3'b011,
		MDU_DIV    = 3'b100,
		MDU_DIVU   = 3'b101,
		MDU_REM    = 3'b110,
		MDU_REMU   = 3'b111
	} mdu_func_e;

	typedef struct packed {
		logic [`MDU_IDX_W-1:0] index;
		mdu_func_e             func;
		logic [`MDU_XLEN-1:0]  op0;
		logic [`MDU_XLEN-1:0]  op1;
	} mdu_req_t;

	typedef struct packed {
		logic [`MDU_IDX_W-1:0] index;
		logic [`MDU_XLEN-1:0]  result;
	} mdu_resp_t;

	// per-cycle strobes from the FSM
	typedef struct packed {
		logic load;
		logic pre;
		logic dshift;
		logic mul_first;
		logic exe;
		logic post;
	} mdu_step_t;

	typedef struct packed {
		logic mul_op;
		logic hi_result;
		logic mulhsu;
	} mdu_op_t;

	typedef struct packed {
		logic op0_signed;
		logic op1_signed;
		logic op0_msb;
		logic neg_result;
		logic div_by_zero;
		logic overflow;
	} mdu_sign_t;

endpackage

// ==== logic/mdu_result_fix.sv ====
`include "mdu_settings.svh"

module mdu_result_fix (
	input  logic                  core_clk,
	input  logic                  core_reset_n,
	input  mdu_pkg::mdu_step_t    i_step,
	input  mdu_pkg::mdu_op_t      i_op,
	input  mdu_pkg::mdu_sign_t    i_sign,
	input  logic [2*`MDU_XLEN:0]  i_reg0,
	input  logic [`MDU_IDX_W-1:0] i_index,
	output mdu_pkg::mdu_resp_t    o_resp
);
	logic [2*`MDU_XLEN-1:0] prod_neg;
	logic [`MDU_XLEN-1:0]   rem;
	logic [`MDU_XLEN-1:0]   rem_neg;
	logic [`MDU_XLEN-1:0]   mul_val;
	logic [`MDU_XLEN-1:0]   div_val;
	logic [`MDU_XLEN-1:0]   post_val;
	logic [`MDU_XLEN-1:0]   special_val;
	logic [`MDU_XLEN-1:0]   held_result;
	logic                   special_done;

	// low half of prod_neg doubles as the negated quotient
	assign prod_neg = ~i_reg0[2*`MDU_XLEN-1:0] + 1'b1;
	assign rem      = i_reg0[2*`MDU_XLEN:`MDU_XLEN+1];
	assign rem_neg  = ~rem + 1'b1;

	always_comb begin
		if (i_op.hi_result)
			mul_val = i_sign.neg_result ? prod_neg[2*`MDU_XLEN-1:`MDU_XLEN] :
				i_reg0[2*`MDU_XLEN-1:`MDU_XLEN];
		else
			mul_val = i_sign.neg_result ? prod_neg[`MDU_XLEN-1:0] : i_reg0[`MDU_XLEN-1:0];

		if (i_op.hi_result)
			div_val = i_sign.neg_result ? rem_neg : rem;
		else
			div_val = i_sign.neg_result ? prod_neg[`MDU_XLEN-1:0] : i_reg0[`MDU_XLEN-1:0];

		// divide by zero returns the dividend, reg0 still holds its magnitude
		if (i_sign.div_by_zero && i_op.hi_result)
			special_val = (i_sign.op0_signed & i_sign.op0_msb) ? prod_neg[`MDU_XLEN-1:0] :
				i_reg0[`MDU_XLEN-1:0];
		else if (i_sign.div_by_zero)
			special_val = '1;
		else if (i_op.hi_result)
			special_val = '0;
		else
			special_val = {1'b1, {(`MDU_XLEN-1){1'b0}}};
	end

	assign post_val     = i_op.mul_op ? mul_val : div_val;
	assign special_done = i_step.exe & (i_sign.div_by_zero | i_sign.overflow);

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n)
			held_result <= '0;
		else if (i_step.post)
			held_result <= post_val;
		else if (special_done)
			held_result <= special_val;
	end

	assign o_resp.index  = i_index;
	assign o_resp.result = i_step.post ? post_val : held_result;

endmodule

// ==== logic/mdu_top.sv ====
`include "mdu_settings.svh"

module mdu_top (
	input  logic                core_clk,
	input  logic                core_reset_n,
	input  logic                i_req_valid,
	input  mdu_pkg::mdu_req_t   i_req,
	output logic                o_req_ready,
	input  logic                i_kill,
	output logic                o_resp_valid,
	output mdu_pkg::mdu_resp_t  o_resp,
	input  logic                i_resp_ready
);
	import mdu_pkg::*;

	mdu_step_t             step;
	mdu_op_t               op;
	mdu_sign_t             sign;
	logic                  need_pre;
	logic [`MDU_IDX_W-1:0] index;
	logic [`MDU_CNT_W-1:0] shift_cnt;
	logic [`MDU_XLEN-1:0]  abs0;
	logic [`MDU_XLEN-1:0]  abs1;
	logic [`MDU_XLEN-1:0]  reg1;
	logic [2*`MDU_XLEN:0]  reg0;

	wire special = sign.div_by_zero | sign.overflow;

	mdu_ctrl u_ctrl (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i_req_valid  (i_req_valid),
		.i_req        (i_req),
		.i_kill       (i_kill),
		.i_resp_ready (i_resp_ready),
		.i_need_pre   (need_pre),
		.i_special    (special),
		.i_shift_cnt  (shift_cnt),
		.o_req_ready  (o_req_ready),
		.o_resp_valid (o_resp_valid),
		.o_step       (step),
		.o_op         (op),
		.o_index      (index)
	);

	mdu_operand_prep u_prep (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i_req        (i_req),
		.i_step       (step),
		.i_op         (op),
		.i_reg0_lo    (reg0[`MDU_XLEN-1:0]),
		.i_reg1       (reg1),
		.o_need_pre   (need_pre),
		.o_sign       (sign),
		.o_abs0       (abs0),
		.o_abs1       (abs1)
	);

	mdu_lzc u_lzc (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i_step       (step),
		.i_reg0_lo    (reg0[`MDU_XLEN-1:0]),
		.i_reg1       (reg1),
		.o_shift_cnt  (shift_cnt)
	);

	mdu_iter_datapath u_datapath (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i_req        (i_req),
		.i_step       (step),
		.i_op         (op),
		.i_sign       (sign),
		.i_abs0       (abs0),
		.i_abs1       (abs1),
		.i_shift_cnt  (shift_cnt),
		.o_reg0       (reg0),
		.o_reg1       (reg1)
	);

	mdu_result_fix u_result (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i_step       (step),
		.i_op         (op),
		.i_sign       (sign),
		.i_reg0       (reg0),
		.i_index      (index),
		.o_resp       (o_resp)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mdu_tb -o mdu_sim &&
./obj_dir/mdu_sim || exit 1

// ==== verification/mdu_tb.sv ====
`include "mdu_settings.svh"

module mdu_tb;
	import mdu_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int CORNER_OPS   = 4 * 4 * 8;
	localparam int RANDOM_OPS   = 12 * 8;
	localparam int SPECIAL_OPS  = 14;
	localparam int BP_OPS       = 16;
	localparam int KILL_ROUNDS  = 4;
	localparam int TOTAL_OPS    = CORNER_OPS + RANDOM_OPS + SPECIAL_OPS + BP_OPS + 2 * KILL_ROUNDS;
	// stall stretches are 4-bit draws
	localparam int STALL_CYCLES   = BP_OPS * 16;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_OPS * 40 + STALL_CYCLES;

	localparam logic [`MDU_XLEN-1:0] MIN_INT = {1'b1, {(`MDU_XLEN-1){1'b0}}};
	localparam logic [`MDU_XLEN-1:0] CORNERS [4] = '{32'd0, 32'd1, 32'hffff_ffff, MIN_INT};

	logic                  core_clk;
	logic                  core_reset_n;
	logic                  i_req_valid;
	mdu_req_t              i_req;
	logic                  o_req_ready;
	logic                  i_kill;
	logic                  o_resp_valid;
	mdu_resp_t             o_resp;
	logic                  i_resp_ready;
	logic [31:0]           lfsr_state;
	logic [`MDU_IDX_W-1:0] next_index;
	int                    cycle_cnt;

	mdu_top DUT (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i_req_valid  (i_req_valid),
		.i_req        (i_req),
		.o_req_ready  (o_req_ready),
		.i_kill       (i_kill),
		.o_resp_valid (o_resp_valid),
		.o_resp       (o_resp),
		.i_resp_ready (i_resp_ready)
	);

	always #2 core_clk = ~core_clk;

	always @(posedge core_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: no progress after %0d cycles", cycle_cnt);
			$display("Test failed");
			$fatal(1, "simulation timeout");
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// M-extension rules worked out on 64-bit operands
	function automatic logic [`MDU_XLEN-1:0] ref_model(input mdu_func_e func,
		input logic [`MDU_XLEN-1:0] a, input logic [`MDU_XLEN-1:0] b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        ua;
		logic [63:0]        ub;
		logic [63:0]        wide;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'b0, a};
		ub = {32'b0, b};
		if (b == '0 && func inside {MDU_DIV, MDU_DIVU}) begin
			wide = '1;
		end else if (b == '0 && func inside {MDU_REM, MDU_REMU}) begin
			wide = ua;
		end else begin
			case (func)
				MDU_MUL:    wide = sa * sb;
				MDU_MULH:   wide = (sa * sb) >> 32;
				MDU_MULHSU: wide = (sa * ub) >> 32;
				MDU_MULHU:  wide = (ua * ub) >> 32;
				MDU_DIV:    wide = sa / sb;
				MDU_DIVU:   wide = ua / ub;
				MDU_REM:    wide = sa % sb;
				default:    wide = ua % ub;
			endcase
		end
		return wide[31:0];
	endfunction

	task automatic compare_result(input mdu_resp_t got, input logic [`MDU_XLEN-1:0] exp);
		if (got.result !== exp) begin
			$display("FAIL %0t o_resp.result got %h expected %h", $time, got.result, exp);
			$display("Test failed");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic compare_index(input mdu_resp_t got, input logic [`MDU_IDX_W-1:0] exp);
		if (got.index !== exp) begin
			$display("FAIL %0t o_resp.index got %h expected %h", $time, got.index, exp);
			$display("Test failed");
			$fatal(1, "index mismatch");
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "handshake mismatch");
		end
	endtask

	// one request through to its handshake, response held for stall cycles
	task automatic run_op(input mdu_func_e func, input logic [`MDU_XLEN-1:0] a,
		input logic [`MDU_XLEN-1:0] b, input logic [`MDU_XLEN-1:0] exp, input int stall);
		logic [`MDU_IDX_W-1:0] idx;
		mdu_resp_t             held;
		idx = next_index;
		next_index = next_index + 1'b1;
		expect_flag("o_req_ready", o_req_ready, 1'b1);
		i_req.index = idx;
		i_req.func  = func;
		i_req.op0   = a;
		i_req.op1   = b;
		i_req_valid = 1'b1;
		@(negedge core_clk);
		i_req_valid = 1'b0;
		expect_flag("o_req_ready", o_req_ready, 1'b0);
		while (!o_resp_valid)
			@(negedge core_clk);
		held = o_resp;
		compare_result(held, exp);
		compare_index(held, idx);
		for (int i = 0; i < stall; i++) begin
			@(negedge core_clk);
			expect_flag("o_resp_valid", o_resp_valid, 1'b1);
			expect_flag("o_req_ready", o_req_ready, 1'b0);
			compare_result(o_resp, held.result);
			compare_index(o_resp, held.index);
		end
		i_resp_ready = 1'b1;
		@(negedge core_clk);
		i_resp_ready = 1'b0;
		expect_flag("o_resp_valid", o_resp_valid, 1'b0);
		expect_flag("o_req_ready", o_req_ready, 1'b1);
	endtask

	task automatic check_reset_state();
		expect_flag("o_req_ready", o_req_ready, 1'b1);
		expect_flag("o_resp_valid", o_resp_valid, 1'b0);
	endtask

	task automatic multiply_ops();
		mdu_func_e            func;
		logic [`MDU_XLEN-1:0] a;
		logic [`MDU_XLEN-1:0] b;
		for (int f = 0; f < 4; f++) begin
			func = mdu_func_e'(f);
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					run_op(func, CORNERS[i], CORNERS[j], ref_model(func, CORNERS[i], CORNERS[j]), 0);
			for (int n = 0; n < 12; n++) begin
				a = rand_bits(32);
				b = rand_bits(32);
				run_op(func, a, b, ref_model(func, a, b), 0);
			end
		end
	endtask

	task automatic divide_ops();
		mdu_func_e            func;
		logic [`MDU_XLEN-1:0] a;
		logic [`MDU_XLEN-1:0] b;
		for (int f = 4; f < 8; f++) begin
			func = mdu_func_e'(f);
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					run_op(func, CORNERS[i], CORNERS[j], ref_model(func, CORNERS[i], CORNERS[j]), 0);
			// narrow divisors give long quotients
			for (int n = 0; n < 12; n++) begin
				a = rand_bits(32);
				b = rand_bits(32) >> rand_bits(5);
				run_op(func, a, b, ref_model(func, a, b), 0);
			end
		end
	endtask

	task automatic special_cases();
		logic [`MDU_XLEN-1:0] a;
		for (int n = 0; n < 3; n++) begin
			a = rand_bits(32);
			run_op(MDU_DIV, a, '0, '1, 0);
			run_op(MDU_DIVU, a, '0, '1, 0);
			run_op(MDU_REM, a, '0, a, 0);
			run_op(MDU_REMU, a, '0, a, 0);
		end
		run_op(MDU_DIV, MIN_INT, '1, MIN_INT, 0);
		run_op(MDU_REM, MIN_INT, '1, '0, 0);
	endtask

	task automatic backpressure_stalls();
		mdu_func_e            func;
		logic [`MDU_XLEN-1:0] a;
		logic [`MDU_XLEN-1:0] b;
		for (int n = 0; n < BP_OPS; n++) begin
			func = mdu_func_e'(rand_bits(3));
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(func, a, b, ref_model(func, a, b), int'(rand_bits(4)));
		end
	endtask

	task automatic kill_and_recover();
		int                   delay;
		mdu_func_e            func;
		logic [`MDU_XLEN-1:0] a;
		logic [`MDU_XLEN-1:0] b;
		for (int n = 0; n < KILL_ROUNDS; n++) begin
			delay = int'(rand_bits(4));
			i_req.index = next_index;
			next_index  = next_index + 1'b1;
			i_req.func  = (n % 2 == 0) ? MDU_MULHU : MDU_DIVU;
			i_req.op0   = 32'hffff_ffff;
			i_req.op1   = (n % 2 == 0) ? rand_bits(32) : 32'd3;
			i_req_valid = 1'b1;
			@(negedge core_clk);
			i_req_valid = 1'b0;
			repeat (delay) begin
				@(negedge core_clk);
				expect_flag("o_resp_valid", o_resp_valid, 1'b0);
			end
			i_kill = 1'b1;
			@(negedge core_clk);
			i_kill = 1'b0;
			repeat (3) begin
				expect_flag("o_req_ready", o_req_ready, 1'b1);
				expect_flag("o_resp_valid", o_resp_valid, 1'b0);
				@(negedge core_clk);
			end
			func = mdu_func_e'(rand_bits(3));
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(func, a, b, ref_model(func, a, b), 0);
		end
	endtask

	initial begin
		core_clk     = 1'b0;
		core_reset_n = 1'b0;
		i_req_valid  = 1'b0;
		i_req        = '0;
		i_kill       = 1'b0;
		i_resp_ready = 1'b0;
		cycle_cnt    = 0;
		lfsr_state   = 32'h4d25_8afd;
		next_index   = '0;
		repeat (RESET_CYCLES) @(negedge core_clk);
		core_reset_n = 1'b1;
		@(negedge core_clk);
		check_reset_state();
		multiply_ops();
		divide_ops();
		special_cases();
		backpressure_stalls();
		kill_and_recover();
		$display("Test completed successfully");
		$finish;
	end

endmodule
